// ==== include/axi_wr_defs.svh ====
`ifndef AXI_WR_DEFS_SVH
`define AXI_WR_DEFS_SVH

// ----------------------------------------
// AXI field widths
// ----------------------------------------
`define AXI_ID_WIDTH        4
`define AXI_ADDR_WIDTH      16
`define AXI_DATA_WIDTH      32
// Wide enough to carry the request count
`define AXI_USER_WIDTH      5
`define AXI_LEN_WIDTH       8
`define AXI_SIZE_WIDTH      3

// ----------------------------------------
// Burst shape and request patterns
// ----------------------------------------
// awlen of 3 gives four beats
`define AXI_WR_BURST_LEN    3
`define AXI_WR_BEAT_BYTES   4
`define AXI_WR_MAX_REQ      16
`define AXI_WR_INCR_STRIDE  16'h0010
`define AXI_WR_WRAP_ADDR    16'h0024
`define AXI_WR_FIXED_ADDR   16'h0030

// Idle cycles ahead of every W beat
`define AXI_WR_BEAT_GAP     3

`endif

// ==== logic/axi_wr_pkg.sv ====
`default_nettype none

`include "axi_wr_defs.svh"

package axi_wr_pkg;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    // Ordered by severity, so a larger code is a worse response
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // ----------------------------------------
    // Channel payloads
    // ----------------------------------------
    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0]   id;
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic [`AXI_LEN_WIDTH-1:0]  len;
        logic [`AXI_SIZE_WIDTH-1:0] size;
        axi_burst_e                 burst;
        logic [`AXI_USER_WIDTH-1:0] user;
    } axi_aw_t;

    typedef struct packed {
        logic [`AXI_DATA_WIDTH-1:0]     data;
        logic [`AXI_DATA_WIDTH/8-1:0]   strb;
        logic                           last;
        logic [`AXI_USER_WIDTH-1:0]     user;
    } axi_w_t;

    typedef struct packed {
        logic [`AXI_ID_WIDTH-1:0] id;
        axi_resp_e                resp;
    } axi_b_t;

    // Beat word tagged with the burst ID and the beat address
    typedef struct packed {
        logic [`AXI_DATA_WIDTH-`AXI_ID_WIDTH-`AXI_ADDR_WIDTH-1:0] pad;
        logic [`AXI_ID_WIDTH-1:0]                                 id;
        logic [`AXI_ADDR_WIDTH-1:0]                               addr;
    } axi_wdata_tag_t;

    typedef union packed {
        logic [`AXI_DATA_WIDTH-1:0] raw;
        axi_wdata_tag_t             tag;
    } axi_wdata_u;

endpackage

`default_nettype wire

// ==== logic/axi_wr_req_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "axi_wr_defs.svh"

module axi_wr_req_gen (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   wr_en,
    input  wire                   busy,
    input  wire                   awready,
    output axi_wr_pkg::axi_aw_t   req,
    output logic                  req_load,
    output axi_wr_pkg::axi_aw_t   aw,
    output logic                  awvalid,
    output logic                  aw_done,
    output logic                  wr_req_finish
);

    import axi_wr_pkg::*;

    localparam int CNT_W = `AXI_USER_WIDTH;
    localparam logic [`AXI_SIZE_WIDTH-1:0] SIZE_CODE =
        `AXI_SIZE_WIDTH'($clog2(`AXI_WR_BEAT_BYTES));

    logic [CNT_W-1:0] req_cnt;

    // ----------------------------------------
    // Request counter
    // ----------------------------------------
    assign wr_req_finish = (req_cnt == CNT_W'(`AXI_WR_MAX_REQ));
    assign req_load      = wr_en & ~busy & ~wr_req_finish;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_cnt <= '0;
        end else if (req_load) begin
            req_cnt <= req_cnt + 1'b1;
        end
    end

    // Pattern picked by the low two count bits
    always_comb begin
        req.id   = req_cnt[`AXI_ID_WIDTH-1:0];
        req.user = req_cnt;
        req.len  = `AXI_LEN_WIDTH'(`AXI_WR_BURST_LEN);
        req.size = SIZE_CODE;
        case (req_cnt[1:0])
            2'd0: begin
                req.addr  = '0;
                req.burst = INCR;
            end
            2'd1: begin
                req.addr  = `AXI_ADDR_WIDTH'(req_cnt) * `AXI_WR_INCR_STRIDE;
                req.burst = INCR;
            end
            2'd2: begin
                req.addr  = `AXI_WR_WRAP_ADDR;
                req.burst = WRAP;
            end
            default: begin
                req.addr  = `AXI_WR_FIXED_ADDR;
                req.burst = FIXED;
            end
        endcase
    end

    // ----------------------------------------
    // AW channel
    // ----------------------------------------
    assign aw_done = awvalid & awready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awvalid <= 1'b0;
        end else if (req_load) begin
            awvalid <= 1'b1;
        end else if (aw_done) begin
            awvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_load) begin
            aw <= req;
        end
    end

    // Stalled address must not change under the slave
    assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(aw))
    else $error("AW payload changed while stalled");

endmodule

`default_nettype wire

// ==== logic/axi_wr_beat_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "axi_wr_defs.svh"

module axi_wr_beat_gen (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire axi_wr_pkg::axi_aw_t req,
    input  wire                   req_load,
    input  wire                   wready,
    output axi_wr_pkg::axi_w_t    w,
    output logic                  wvalid,
    output logic                  w_done
);

    import axi_wr_pkg::*;

    localparam int GAP_W = $clog2(`AXI_WR_BEAT_GAP + 1);
    localparam logic [GAP_W-1:0] GAP = GAP_W'(`AXI_WR_BEAT_GAP);

    axi_aw_t                    req_r;
    logic [`AXI_LEN_WIDTH-1:0]  beat_idx;
    logic [GAP_W-1:0]           gap_cnt;
    logic                       w_fire;
    logic                       beat_last;
    logic [`AXI_ADDR_WIDTH-1:0] beat_bytes;
    logic [`AXI_ADDR_WIDTH-1:0] offset;
    logic [`AXI_ADDR_WIDTH-1:0] aligned;
    logic [`AXI_ADDR_WIDTH-1:0] wrap_mask;
    logic [`AXI_ADDR_WIDTH-1:0] beat_addr;
    axi_wdata_u                 wdata;

    always_ff @(posedge clk) begin
        if (req_load) begin
            req_r <= req;
        end
    end

    // ----------------------------------------
    // Beat address
    // ----------------------------------------
    assign beat_bytes = `AXI_ADDR_WIDTH'(1) << req_r.size;
    assign offset     = `AXI_ADDR_WIDTH'(beat_idx) << req_r.size;
    assign aligned    = req_r.addr & ~(beat_bytes - 1'b1);
    // Window is the whole burst, len+1 beats
    assign wrap_mask  = (`AXI_ADDR_WIDTH'(req_r.len) + 1'b1) * beat_bytes - 1'b1;

    always_comb begin
        case (req_r.burst)
            FIXED:   beat_addr = req_r.addr;
            WRAP:    beat_addr = (aligned & ~wrap_mask) | ((aligned + offset) & wrap_mask);
            default: beat_addr = aligned + offset;
        endcase
    end

    // ----------------------------------------
    // Beat pacing
    // ----------------------------------------
    assign w_fire    = wvalid & wready;
    assign beat_last = (beat_idx == req_r.len);
    assign w_done    = w_fire & beat_last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gap_cnt  <= '0;
            beat_idx <= '0;
            wvalid   <= 1'b0;
        end else if (req_load) begin
            gap_cnt  <= GAP;
            beat_idx <= '0;
        end else if (w_fire) begin
            wvalid <= 1'b0;
            if (!beat_last) begin
                beat_idx <= beat_idx + 1'b1;
                gap_cnt  <= GAP;
            end
        end else if (gap_cnt != '0) begin
            gap_cnt <= gap_cnt - 1'b1;
            // Last idle cycle, beat goes valid next
            if (gap_cnt == GAP_W'(1)) begin
                wvalid <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // W payload
    // ----------------------------------------
    always_comb begin
        wdata.tag.pad  = '0;
        wdata.tag.id   = req_r.id;
        wdata.tag.addr = beat_addr;
        w.data = wdata.raw;
        w.strb = '1;
        w.last = wvalid & beat_last;
        w.user = req_r.user;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(w))
    else $error("W beat dropped or changed while stalled");

endmodule

`default_nettype wire

// ==== logic/axi_wr_resp_trk.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "axi_wr_defs.svh"

module axi_wr_resp_trk (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        req_load,
    input  wire                        aw_done,
    input  wire                        w_done,
    input  wire [`AXI_ID_WIDTH-1:0]    aw_id,
    input  wire axi_wr_pkg::axi_b_t    b,
    input  wire                        bvalid,
    output logic                       bready,
    output logic                       busy,
    output logic                       wr_resp_err
);

    import axi_wr_pkg::*;

    logic [`AXI_ID_WIDTH-1:0] id_r;
    logic                     aw_seen;
    logic                     w_seen;
    logic                     b_fire;

    always_ff @(posedge clk) begin
        if (aw_done) begin
            id_r <= aw_id;
        end
    end

    // ----------------------------------------
    // Completion tracking
    // ----------------------------------------
    // Response only accepted once address and data are both out
    assign bready = aw_seen & w_seen;
    assign b_fire = bvalid & bready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
            busy    <= 1'b0;
        end else begin
            if (req_load) begin
                busy <= 1'b1;
            end else if (b_fire) begin
                busy <= 1'b0;
            end
            if (b_fire) begin
                aw_seen <= 1'b0;
                w_seen  <= 1'b0;
            end else begin
                aw_seen <= aw_seen | aw_done;
                w_seen  <= w_seen | w_done;
            end
        end
    end

    // Sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_resp_err <= 1'b0;
        end else if (b_fire && (b.resp inside {SLVERR, DECERR})) begin
            wr_resp_err <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) b_fire |-> b.id == id_r)
    else $error("B ID does not match outstanding AW ID");

endmodule

`default_nettype wire

// ==== logic/axi_mst_wr.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_mst_wr (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        wr_en,
    output logic                       wr_req_finish,
    output logic                       wr_resp_err,
    // AW channel
    output axi_wr_pkg::axi_aw_t        aw,
    output logic                       awvalid,
    input  wire                        awready,
    // W channel
    output axi_wr_pkg::axi_w_t         w,
    output logic                       wvalid,
    input  wire                        wready,
    // B channel
    input  wire axi_wr_pkg::axi_b_t    b,
    input  wire                        bvalid,
    output logic                       bready
);

    import axi_wr_pkg::*;

    axi_aw_t req;
    logic    req_load;
    logic    aw_done;
    logic    w_done;
    logic    busy;

    axi_wr_req_gen u_req_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .busy          (busy),
        .awready       (awready),
        .req           (req),
        .req_load      (req_load),
        .aw            (aw),
        .awvalid       (awvalid),
        .aw_done       (aw_done),
        .wr_req_finish (wr_req_finish)
    );

    axi_wr_beat_gen u_beat_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_load (req_load),
        .wready   (wready),
        .w        (w),
        .wvalid   (wvalid),
        .w_done   (w_done)
    );

    axi_wr_resp_trk u_resp_trk (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_load    (req_load),
        .aw_done     (aw_done),
        .w_done      (w_done),
        .aw_id       (aw.id),
        .b           (b),
        .bvalid      (bvalid),
        .bready      (bready),
        .busy        (busy),
        .wr_resp_err (wr_resp_err)
    );

endmodule

`default_nettype wire

// ==== testbench/axi_mst_wr_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "axi_wr_defs.svh"

module axi_mst_wr_tb;

    import axi_wr_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic      clk;
    logic      rst_n;
    logic      wr_en;
    logic      wr_req_finish;
    logic      wr_resp_err;
    axi_aw_t   aw;
    logic      awvalid;
    logic      awready;
    axi_w_t    w;
    logic      wvalid;
    logic      wready;
    axi_b_t    b;
    logic      bvalid;
    logic      bready;

    integer    seed = 32'h7ef9b98b;
    int        checks;
    int        errors;
    int        tests_run;
    axi_resp_e resp_sel;

    // Transfers seen on the bus for the current request
    axi_aw_t                  aw_q[$];
    axi_w_t                   w_q[$];
    logic                     aw_flag;
    logic                     wl_flag;
    logic [`AXI_ID_WIDTH-1:0] aw_id_seen;
    logic                     aw_hold;
    logic                     w_hold;
    axi_aw_t                  aw_prev;
    axi_w_t                   w_prev;

    axi_mst_wr DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_req_finish (wr_req_finish),
        .wr_resp_err   (wr_resp_err),
        .aw            (aw),
        .awvalid       (awvalid),
        .awready       (awready),
        .w             (w),
        .wvalid        (wvalid),
        .wready        (wready),
        .b             (b),
        .bvalid        (bvalid),
        .bready        (bready)
    );

    always #10 clk = ~clk;

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_aw(input string name, input axi_aw_t got, input axi_aw_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_w(input string name, input axi_w_t got, input axi_w_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_b_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, got);
        end
    endtask

    // ----------------------------------------
    // Expected values from the pattern table
    // ----------------------------------------
    function automatic axi_aw_t expected_aw(input int n);
        axi_aw_t e;
        e.id   = `AXI_ID_WIDTH'(n);
        e.user = `AXI_USER_WIDTH'(n);
        e.len  = `AXI_LEN_WIDTH'(`AXI_WR_BURST_LEN);
        e.size = `AXI_SIZE_WIDTH'($clog2(`AXI_WR_BEAT_BYTES));
        case (n % 4)
            0: begin
                e.addr  = 16'h0000;
                e.burst = INCR;
            end
            1: begin
                e.addr  = `AXI_ADDR_WIDTH'(n * 'h10);
                e.burst = INCR;
            end
            2: begin
                e.addr  = 16'h0024;
                e.burst = WRAP;
            end
            default: begin
                e.addr  = 16'h0030;
                e.burst = FIXED;
            end
        endcase
        return e;
    endfunction

    function automatic axi_w_t expected_w(input axi_aw_t a, input int i);
        axi_wdata_u d;
        axi_w_t     e;
        logic [`AXI_ADDR_WIDTH-1:0] step;
        step = `AXI_ADDR_WIDTH'(4 * i);
        d.tag.pad = '0;
        d.tag.id  = a.id;
        case (a.burst)
            FIXED:   d.tag.addr = a.addr;
            // Start at 0x24 runs up to 0x2C, then back to 0x20
            WRAP: begin
                case (i)
                    0:       d.tag.addr = 16'h0024;
                    1:       d.tag.addr = 16'h0028;
                    2:       d.tag.addr = 16'h002c;
                    default: d.tag.addr = 16'h0020;
                endcase
            end
            default: d.tag.addr = a.addr + step;
        endcase
        e.data = d.raw;
        e.strb = '1;
        e.last = (i == 3);
        e.user = a.user;
        return e;
    endfunction

    // ----------------------------------------
    // Bus monitor and slave responder
    // ----------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            aw_flag = 1'b0;
            wl_flag = 1'b0;
            aw_hold = 1'b0;
            w_hold  = 1'b0;
        end else begin
            if (aw_hold) begin
                check_b_flag("awvalid", awvalid, 1'b1);
                check_aw("aw", aw, aw_prev);
            end
            if (w_hold) begin
                check_b_flag("wvalid", wvalid, 1'b1);
                check_w("w", w, w_prev);
            end
            if (bready && !(aw_flag && wl_flag))
                check_b_flag("bready", bready, 1'b0);
            if (awvalid && awready) begin
                aw_q.push_back(aw);
                aw_flag    = 1'b1;
                aw_id_seen = aw.id;
            end
            if (wvalid && wready) begin
                w_q.push_back(w);
                if (w.last)
                    wl_flag = 1'b1;
            end
            if (bvalid && bready) begin
                aw_flag = 1'b0;
                wl_flag = 1'b0;
            end
            aw_hold = awvalid && !awready;
            aw_prev = aw;
            w_hold  = wvalid && !wready;
            w_prev  = w;
        end
    end

    always @(negedge clk) begin
        awready = ($random(seed) & 3) != 0;
        wready  = ($random(seed) & 3) != 0;
        bvalid  = rst_n && aw_flag && wl_flag;
        b.id    = aw_id_seen;
        b.resp  = resp_sel;
    end

    // ----------------------------------------
    // Sequencing helpers
    // ----------------------------------------
    task automatic apply_reset();
        rst_n = 1'b0;
        wr_en = 1'b0;
        repeat (10) @(negedge clk);
        aw_q.delete();
        w_q.delete();
        rst_n = 1'b1;
    endtask

    task automatic pulse_wr_en();
        wr_en = 1'b1;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // Completion is bready opening and then closing again
    task automatic wait_complete(input int n);
        int cycles;
        cycles = 0;
        while (bready !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (bready !== 1'b1) begin
            errors++;
            $display("Timeout: request %0d never opened bready", n);
        end
        cycles = 0;
        while (bready !== 1'b0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (bready !== 1'b0) begin
            errors++;
            $display("Timeout: request %0d never took its B response", n);
        end
    endtask

    task automatic run_request(input int n, input logic exp_err);
        axi_aw_t ea;
        int      i;
        ea = expected_aw(n);
        pulse_wr_en();
        wait_complete(n);
        if (aw_q.size() != 1) begin
            errors++;
            $display("Request %0d produced %0d AW transfers instead of one", n, aw_q.size());
        end else begin
            check_aw($sformatf("aw of request %0d", n), aw_q[0], ea);
        end
        if (w_q.size() != 4) begin
            errors++;
            $display("Request %0d produced %0d W beats instead of four", n, w_q.size());
        end else begin
            for (i = 0; i < 4; i++)
                check_w($sformatf("w beat %0d of request %0d", i, n), w_q[i], expected_w(ea, i));
        end
        check_b_flag("wr_resp_err", wr_resp_err, exp_err);
        check_b_flag("wr_req_finish", wr_req_finish, n == `AXI_WR_MAX_REQ - 1);
        aw_q.delete();
        w_q.delete();
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        $display("Test %-14s finished with %0d errors", name, errors - err_start);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_reset_idle();
        int err_start;
        err_start = errors;
        apply_reset();
        check_b_flag("awvalid", awvalid, 1'b0);
        check_b_flag("wvalid", wvalid, 1'b0);
        check_b_flag("bready", bready, 1'b0);
        check_b_flag("wr_req_finish", wr_req_finish, 1'b0);
        check_b_flag("wr_resp_err", wr_resp_err, 1'b0);
        repeat (20) @(negedge clk);
        if (aw_q.size() != 0) begin
            errors++;
            $display("AW transfer seen while wr_en stayed low");
        end
        report_test("reset_idle", err_start);
    endtask

    task automatic test_bursts();
        int err_start;
        int n;
        err_start = errors;
        resp_sel  = OKAY;
        for (n = 0; n < `AXI_WR_MAX_REQ; n++)
            run_request(n, 1'b0);
        report_test("bursts", err_start);
    endtask

    task automatic test_finish_flag();
        int err_start;
        err_start = errors;
        check_b_flag("wr_req_finish", wr_req_finish, 1'b1);
        repeat (3) begin
            pulse_wr_en();
            repeat (10) @(negedge clk);
        end
        if (aw_q.size() != 0) begin
            errors++;
            $display("AW transfer seen after the request limit was reached");
        end
        check_b_flag("awvalid", awvalid, 1'b0);
        report_test("finish_flag", err_start);
    endtask

    task automatic test_resp_error();
        int err_start;
        err_start = errors;
        apply_reset();
        resp_sel = OKAY;
        run_request(0, 1'b0);
        resp_sel = SLVERR;
        run_request(1, 1'b1);
        // Flag is sticky across later good responses
        resp_sel = OKAY;
        run_request(2, 1'b1);
        report_test("resp_error", err_start);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        wr_en     = 1'b0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        b         = '0;
        resp_sel  = OKAY;
        checks    = 0;
        errors    = 0;
        tests_run = 0;
        aw_flag   = 1'b0;
        wl_flag   = 1'b0;
        test_reset_idle();
        test_bursts();
        test_finish_flag();
        test_resp_error();
        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== axi_mst_wr.f ====
+incdir+include
logic/axi_wr_pkg.sv
logic/axi_wr_req_gen.sv
logic/axi_wr_beat_gen.sv
logic/axi_wr_resp_trk.sv
logic/axi_mst_wr.sv
testbench/axi_mst_wr_tb.sv

// ==== Bender.yml ====
package:
  name: axi_mst_wr

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/axi_wr_pkg.sv
      - logic/axi_wr_req_gen.sv
      - logic/axi_wr_beat_gen.sv
      - logic/axi_wr_resp_trk.sv
      - logic/axi_mst_wr.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/axi_mst_wr_tb.sv
